/* flist.f */
+incdir+design
design/rdp_ctrl_pkg.sv
design/rdp_data_pkg.sv
design/chunk_addr_looper.sv
design/chunk_buffer.sv
design/chunk_reader.sv
design/read_pipeline.sv
verif/read_pipeline_chk.sv
verif/read_pipeline_tb.sv

/* Bender.yml */
package:
  name: read_pipeline

sources:
  - include_dirs:
      - design
    files:
      - design/rdp_ctrl_pkg.sv
      - design/rdp_data_pkg.sv
      - design/chunk_addr_looper.sv
      - design/chunk_buffer.sv
      - design/chunk_reader.sv
      - design/read_pipeline.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verif/read_pipeline_chk.sv
      - verif/read_pipeline_tb.sv

/* verif/read_pipeline_tb.sv */
`include "rdp_consts.svh"

module read_pipeline_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import rdp_ctrl_pkg::*;
	import rdp_data_pkg::*;

	localparam int MAX_DELAY = 3;
	localparam int N_CMDS = 29;
	localparam int WATCHDOG_NS = N_CMDS * `RDP_CHUNK_WORDS * (MAX_DELAY + 1) * 20 + 10000;
	localparam data_t PAD_VALUE = 16'hdead;

	logic   i_clk;
	logic   i_rst;
	logic   i_cmd_rdy, o_cmd_ack;
	gaddr_t i_cmd_addr;
	len_t   i_cmd_len;
	logic   o_dramra_rdy, i_dramra_ack;
	gaddr_t o_dramra;
	logic   i_dramrd_rdy, o_dramrd_ack;
	data_t  i_dramrd;
	logic   o_sramrd_rdy, i_sramrd_ack, o_sramrd_last;
	vec_t   o_sramrd;
	data_t  i_pad_value;

	integer seed = 32'he030;
	int     n_errors = 0;
	bit     rand_mode = 1'b0;
	bit     sink_hold = 1'b0;
	int     ra_wait = 0;
	int     sr_wait = 0;
	logic   cmd_fire = 1'b0;
	logic   rd_fire = 1'b0;
	// addresses waiting for their data, and every address seen
	gaddr_t rd_q [$];
	gaddr_t ra_log [$];
	vec_t   exp_vec_q [$];
	logic   exp_last_q [$];
	vec_t   got_vec_q [$];
	logic   got_last_q [$];

	read_pipeline dut_i (.*);

	bind read_pipeline read_pipeline_chk chk_i (.*);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	// ====================================================================
	// DRAM and vector sink models
	// ====================================================================

	function automatic data_t dram_word(input gaddr_t a);
		return data_t'(a * 3 + 1);
	endfunction

	function automatic int pick_delay();
		if (!rand_mode) return 0;
		return $unsigned($random(seed)) % (MAX_DELAY + 1);
	endfunction

	// transfers where the DUT gives the ack, seen at the edge itself
	always @(posedge i_clk) begin
		cmd_fire <= i_cmd_rdy && o_cmd_ack;
		rd_fire  <= i_dramrd_rdy && o_dramrd_ack;
	end

	initial begin
		forever begin
			@(negedge i_clk);
			// data returns in address order
			if (rd_fire) i_dramrd_rdy = 1'b0;
			if (!i_dramrd_rdy && rd_q.size() > 0) begin
				i_dramrd     = dram_word(rd_q.pop_front());
				i_dramrd_rdy = 1'b1;
			end
			i_dramra_ack = 1'b0;
			if (ra_wait > 0) begin
				ra_wait--;
			end else if (o_dramra_rdy) begin
				i_dramra_ack = 1'b1;
				rd_q.push_back(o_dramra);
				ra_log.push_back(o_dramra);
				ra_wait = pick_delay();
			end
			i_sramrd_ack = 1'b0;
			if (sr_wait > 0) begin
				sr_wait--;
			end else if (o_sramrd_rdy && !sink_hold) begin
				i_sramrd_ack = 1'b1;
				got_vec_q.push_back(o_sramrd);
				got_last_q.push_back(o_sramrd_last);
				sr_wait = pick_delay();
			end
		end
	end

	// ====================================================================
	// compare and command helpers
	// ====================================================================

	task automatic compare_addr(input string name, input gaddr_t exp, input gaddr_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			n_errors++;
		end
	endtask

	task automatic compare_vec(input string name, input vec_t exp, input vec_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			n_errors++;
		end
	endtask

	task automatic compare_last(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s: expected last %b, actual %b", name, exp, act);
			n_errors++;
		end
	endtask

	// present a command and queue the vectors it must produce
	task automatic drive_cmd(input gaddr_t base, input len_t len);
		int   n_vec;
		int   pos;
		vec_t e;
		n_vec = (int'(len) + `RDP_VSIZE - 1) / `RDP_VSIZE;
		for (int v = 0; v < n_vec; v++) begin
			for (int j = 0; j < `RDP_VSIZE; j++) begin
				pos  = v * `RDP_VSIZE + j;
				e[j] = (pos < len) ? dram_word(base + gaddr_t'(pos)) : PAD_VALUE;
			end
			exp_vec_q.push_back(e);
			exp_last_q.push_back(v == n_vec - 1);
		end
		i_cmd_addr = base;
		i_cmd_len  = len;
		i_cmd_rdy  = 1'b1;
	endtask

	task automatic wait_cmd_ack();
		@(negedge i_clk);
		while (!cmd_fire) @(negedge i_clk);
		i_cmd_rdy = 1'b0;
	endtask

	task automatic drain_check(input string name);
		while (exp_vec_q.size() > 0) begin
			while (got_vec_q.size() == 0) @(negedge i_clk);
			compare_vec(name, exp_vec_q.pop_front(), got_vec_q.pop_front());
			compare_last(name, exp_last_q.pop_front(), got_last_q.pop_front());
		end
	endtask

	// ====================================================================
	// directed tests
	// ====================================================================

	task automatic idle_after_reset();
		repeat (6) begin
			@(negedge i_clk);
			if (o_cmd_ack || o_dramra_rdy || o_dramrd_ack || o_sramrd_rdy) begin
				$display("idle_after_reset: a handshake output rose with no command");
				n_errors++;
			end
		end
	endtask

	task automatic full_chunk();
		ra_log.delete();
		drive_cmd(32'h0000_1000, len_t'(`RDP_CHUNK_WORDS));
		wait_cmd_ack();
		drain_check("full_chunk");
		if (ra_log.size() != `RDP_CHUNK_WORDS) begin
			$display("full_chunk: wrong number of DRAM addresses, %0d", ra_log.size());
			n_errors++;
		end
		foreach (ra_log[i]) compare_addr("full_chunk", gaddr_t'(32'h1000 + i), ra_log[i]);
	endtask

	task automatic short_chunks();
		len_t lens [3];
		lens = '{len_t'(1), len_t'(3), len_t'(5)};
		foreach (lens[i]) begin
			drive_cmd(gaddr_t'(32'h2000 + i * 16), lens[i]);
			wait_cmd_ack();
		end
		drain_check("short_chunks");
	endtask

	task automatic slot_backpressure();
		sink_hold = 1'b1;
		for (int i = 0; i < `RDP_N_SLOTS; i++) begin
			drive_cmd(gaddr_t'(32'h3000 + i * 32), len_t'(`RDP_CHUNK_WORDS - i));
			wait_cmd_ack();
		end
		// one more than the slots can hold
		drive_cmd(32'h0000_4000, len_t'(6));
		repeat (3 * `RDP_CHUNK_WORDS) begin
			@(negedge i_clk);
			if (cmd_fire) begin
				$display("slot_backpressure: a command was accepted with every slot taken");
				n_errors++;
			end
		end
		@(posedge i_clk);
		sink_hold = 1'b0;
		wait_cmd_ack();
		drain_check("slot_backpressure");
	endtask

	task automatic random_traffic();
		gaddr_t base;
		len_t   len;
		rand_mode = 1'b1;
		repeat (20) begin
			base = $random(seed);
			len  = len_t'($unsigned($random(seed)) % `RDP_CHUNK_WORDS + 1);
			drive_cmd(base, len);
			wait_cmd_ack();
		end
		drain_check("random_traffic");
		rand_mode = 1'b0;
	endtask

	initial begin
		i_rst        = 1'b0;
		i_cmd_rdy    = 1'b0;
		i_cmd_addr   = '0;
		i_cmd_len    = '0;
		i_dramra_ack = 1'b0;
		i_dramrd_rdy = 1'b0;
		i_dramrd     = '0;
		i_sramrd_ack = 1'b0;
		i_pad_value  = PAD_VALUE;
		repeat (4) @(negedge i_clk);
		i_rst = 1'b1;
		idle_after_reset();
		full_chunk();
		short_chunks();
		slot_backpressure();
		random_traffic();
		repeat (2 * `RDP_CHUNK_WORDS) @(negedge i_clk);
		if (got_vec_q.size() != 0) begin
			$display("%0d output vectors arrived with no command behind them", got_vec_q.size());
			n_errors++;
		end
		n_errors += dut_i.chk_i.n_assert_fail;
		$display("errors: %0d, of them assertion failures: %0d", n_errors,
			dut_i.chk_i.n_assert_fail);
		if (n_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests were still running after %0d ns", WATCHDOG_NS);
		$display("sim failed");
		$finish;
	end

endmodule

/* verif/read_pipeline_chk.sv */
module read_pipeline_chk (
	input logic                 i_clk,
	input logic                 i_rst,
	input logic                 i_cmd_rdy,
	input logic                 o_cmd_ack,
	input logic                 o_dramra_rdy,
	input logic                 i_dramra_ack,
	input rdp_data_pkg::gaddr_t o_dramra,
	input logic                 i_dramrd_rdy,
	input logic                 o_dramrd_ack,
	input logic                 o_sramrd_rdy,
	input logic                 i_sramrd_ack,
	input rdp_data_pkg::vec_t   o_sramrd,
	input logic                 o_sramrd_last
);
	timeunit 1ns;
	timeprecision 1ps;

	int n_assert_fail = 0;

	// address stays put until the DRAM takes it
	dramra_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_dramra_rdy && !i_dramra_ack |=> o_dramra_rdy && $stable(o_dramra))
	else begin
		n_assert_fail++;
		$error("dramra rdy or address changed before ack");
	end

	sramrd_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_sramrd_rdy && !i_sramrd_ack |=>
		o_sramrd_rdy && $stable(o_sramrd) && $stable(o_sramrd_last))
	else begin
		n_assert_fail++;
		$error("sramrd rdy or vector changed before ack");
	end

	cmd_ack_rdy: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_cmd_ack |-> i_cmd_rdy)
	else begin
		n_assert_fail++;
		$error("o_cmd_ack high without i_cmd_rdy");
	end

	dramrd_ack_rdy: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_dramrd_ack |-> i_dramrd_rdy)
	else begin
		n_assert_fail++;
		$error("o_dramrd_ack high without i_dramrd_rdy");
	end

endmodule

/* design/read_pipeline.sv */
module read_pipeline (
	input  logic                 i_clk,
	input  logic                 i_rst,
	// command
	input  logic                 i_cmd_rdy,
	output logic                 o_cmd_ack,
	input  rdp_data_pkg::gaddr_t i_cmd_addr,
	input  rdp_ctrl_pkg::len_t   i_cmd_len,
	// DRAM read address
	output logic                 o_dramra_rdy,
	input  logic                 i_dramra_ack,
	output rdp_data_pkg::gaddr_t o_dramra,
	// DRAM read data, in address order
	input  logic                 i_dramrd_rdy,
	output logic                 o_dramrd_ack,
	input  rdp_data_pkg::data_t  i_dramrd,
	// output vectors
	output logic                 o_sramrd_rdy,
	input  logic                 i_sramrd_ack,
	output rdp_data_pkg::vec_t   o_sramrd,
	output logic                 o_sramrd_last,
	input  rdp_data_pkg::data_t  i_pad_value
);
	import rdp_ctrl_pkg::*;
	import rdp_data_pkg::*;

	// looper to buffer
	logic  buf_full;
	logic  alloc;
	len_t  alloc_len;

	// buffer to reader
	logic  chunk_done;
	len_t  chunk_len;
	vidx_t rd_vidx;
	vec_t  rd_vec;
	logic  free;

	chunk_addr_looper u_looper (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_cmd_rdy    (i_cmd_rdy),
		.o_cmd_ack    (o_cmd_ack),
		.i_cmd_addr   (i_cmd_addr),
		.i_cmd_len    (i_cmd_len),
		.i_buf_full   (buf_full),
		.o_alloc      (alloc),
		.o_alloc_len  (alloc_len),
		.o_dramra_rdy (o_dramra_rdy),
		.i_dramra_ack (i_dramra_ack),
		.o_dramra     (o_dramra)
	);

	chunk_buffer u_buffer (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_alloc      (alloc),
		.i_alloc_len  (alloc_len),
		.o_full       (buf_full),
		.i_dramrd_rdy (i_dramrd_rdy),
		.o_dramrd_ack (o_dramrd_ack),
		.i_dramrd     (i_dramrd),
		.o_chunk_done (chunk_done),
		.o_chunk_len  (chunk_len),
		.i_rd_vidx    (rd_vidx),
		.o_rd_vec     (rd_vec),
		.i_free       (free)
	);

	chunk_reader u_reader (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_chunk_done  (chunk_done),
		.i_chunk_len   (chunk_len),
		.o_rd_vidx     (rd_vidx),
		.i_rd_vec      (rd_vec),
		.i_pad_value   (i_pad_value),
		.o_free        (free),
		.o_sramrd_rdy  (o_sramrd_rdy),
		.i_sramrd_ack  (i_sramrd_ack),
		.o_sramrd      (o_sramrd),
		.o_sramrd_last (o_sramrd_last)
	);

endmodule

/* design/chunk_reader.sv */
`include "rdp_consts.svh"

module chunk_reader (
	input  logic                i_clk,
	input  logic                i_rst,
	// chunk hand-off from the buffer
	input  logic                i_chunk_done,
	input  rdp_ctrl_pkg::len_t  i_chunk_len,
	output rdp_ctrl_pkg::vidx_t o_rd_vidx,
	input  rdp_data_pkg::vec_t  i_rd_vec,
	input  rdp_data_pkg::data_t i_pad_value,
	output logic                o_free,
	// SRAM read vector channel
	output logic                o_sramrd_rdy,
	input  logic                i_sramrd_ack,
	output rdp_data_pkg::vec_t  o_sramrd,
	output logic                o_sramrd_last
);
	import rdp_ctrl_pkg::*;

	localparam int VW_BW = $clog2(`RDP_VSIZE);

	read_state_e state;
	vidx_t       vidx;
	vidx_t       last_vidx;
	logic        vec_xfer;

	// ================================================================
	// vector stepping
	// ================================================================

	// index of the vector that holds word len-1
	assign last_vidx = vidx_t'((i_chunk_len - len_t'(1)) >> VW_BW);

	assign o_rd_vidx     = vidx;
	assign o_sramrd_rdy  = (state == READ_VEC);
	assign o_sramrd_last = (vidx == last_vidx);
	assign vec_xfer      = o_sramrd_rdy && i_sramrd_ack;

	// slot goes back with the final transfer
	assign o_free = vec_xfer && o_sramrd_last;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state <= READ_IDLE;
			vidx  <= '0;
		end else begin
			case (state)
				READ_IDLE: begin
					if (i_chunk_done) begin
						state <= READ_VEC;
						vidx  <= '0;
					end
				end
				READ_VEC: begin
					if (vec_xfer) begin
						if (o_sramrd_last) begin
							state <= READ_IDLE;
						end else begin
							vidx <= vidx + vidx_t'(1);
						end
					end
				end
				default: begin
					state <= READ_IDLE;
				end
			endcase
		end
	end

	// ================================================================
	// tail padding
	// ================================================================

	always_comb begin
		for (int j = 0; j < `RDP_VSIZE; j++) begin
			if (len_t'(vidx) * len_t'(`RDP_VSIZE) + len_t'(j) >= i_chunk_len) begin
				o_sramrd[j] = i_pad_value;
			end else begin
				o_sramrd[j] = i_rd_vec[j];
			end
		end
	end

endmodule

/* design/chunk_buffer.sv */
`include "rdp_consts.svh"

module chunk_buffer (
	input  logic                  i_clk,
	input  logic                  i_rst,
	// allocation from the looper
	input  logic                  i_alloc,
	input  rdp_ctrl_pkg::len_t    i_alloc_len,
	output logic                  o_full,
	// DRAM read data channel
	input  logic                  i_dramrd_rdy,
	output logic                  o_dramrd_ack,
	input  rdp_data_pkg::data_t   i_dramrd,
	// chunk hand-off to the reader
	output logic                  o_chunk_done,
	output rdp_ctrl_pkg::len_t    o_chunk_len,
	input  rdp_ctrl_pkg::vidx_t   i_rd_vidx,
	output rdp_data_pkg::vec_t    o_rd_vec,
	input  logic                  i_free
);
	import rdp_ctrl_pkg::*;
	import rdp_data_pkg::*;

	localparam int WIDX_BW   = $clog2(`RDP_CHUNK_WORDS);
	localparam int VW_BW     = $clog2(`RDP_VSIZE);
	localparam int CNT_BW    = $clog2(`RDP_N_SLOTS + 1);
	localparam int MEM_WORDS = `RDP_N_SLOTS * `RDP_CHUNK_WORDS;

	// slot ring pointers
	slot_t                   alloc_ptr;
	slot_t                   wr_slot;
	slot_t                   rd_slot;
	len_t                    wr_cnt;
	logic [CNT_BW - 1:0]     count;
	logic [CNT_BW - 1:0]     n_done;
	logic [`RDP_N_SLOTS-1:0] slot_done;
	len_t                    slot_len [`RDP_N_SLOTS];
	data_t                   mem [MEM_WORDS];
	laddr_t                  wr_laddr;
	logic                    wr_expect;
	logic                    wr_xfer;
	logic                    wr_last;

	// ================================================================
	// allocate / free semaphore
	// ================================================================

	assign o_full = (count == CNT_BW'(`RDP_N_SLOTS));

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			count     <= '0;
			alloc_ptr <= '0;
			rd_slot   <= '0;
		end else begin
			case ({i_alloc, i_free})
				2'b10:   count <= count + CNT_BW'(1);
				2'b01:   count <= count - CNT_BW'(1);
				default: count <= count;
			endcase
			if (i_alloc) begin
				alloc_ptr <= alloc_ptr + slot_t'(1);
			end
			if (i_free) begin
				rd_slot <= rd_slot + slot_t'(1);
			end
		end
	end

	// ================================================================
	// DRAM write collector
	// ================================================================

	// allocated slots not yet filled still expect data
	always_comb begin
		n_done = '0;
		for (int i = 0; i < `RDP_N_SLOTS; i++) begin
			n_done = n_done + CNT_BW'(slot_done[i]);
		end
	end

	assign wr_expect    = (count > n_done);
	assign o_dramrd_ack = i_dramrd_rdy && wr_expect;
	assign wr_xfer      = o_dramrd_ack;
	assign wr_last      = (wr_cnt == slot_len[wr_slot] - len_t'(1));
	assign wr_laddr     = {wr_slot, wr_cnt[WIDX_BW - 1:0]};

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			wr_slot   <= '0;
			wr_cnt    <= '0;
			slot_done <= '0;
		end else begin
			if (wr_xfer) begin
				if (wr_last) begin
					wr_cnt             <= '0;
					wr_slot            <= wr_slot + slot_t'(1);
					slot_done[wr_slot] <= 1'b1;
				end else begin
					wr_cnt <= wr_cnt + len_t'(1);
				end
			end
			// the freed slot is never the one being written
			if (i_free) begin
				slot_done[rd_slot] <= 1'b0;
			end
		end
	end

	// slot memory and per slot length
	always_ff @(posedge i_clk) begin
		if (i_alloc) begin
			slot_len[alloc_ptr] <= i_alloc_len;
		end
		if (wr_xfer) begin
			mem[wr_laddr] <= i_dramrd;
		end
	end

	// ================================================================
	// read side, oldest slot only
	// ================================================================

	assign o_chunk_done = slot_done[rd_slot];
	assign o_chunk_len  = slot_len[rd_slot];

	always_comb begin
		for (int j = 0; j < `RDP_VSIZE; j++) begin
			o_rd_vec[j] = mem[{rd_slot, i_rd_vidx, VW_BW'(j)}];
		end
	end

endmodule

/* design/chunk_addr_looper.sv */
module chunk_addr_looper (
	input  logic                 i_clk,
	input  logic                 i_rst,
	// command channel
	input  logic                 i_cmd_rdy,
	output logic                 o_cmd_ack,
	input  rdp_data_pkg::gaddr_t i_cmd_addr,
	input  rdp_ctrl_pkg::len_t   i_cmd_len,
	// slot allocation towards the buffer
	input  logic                 i_buf_full,
	output logic                 o_alloc,
	output rdp_ctrl_pkg::len_t   o_alloc_len,
	// DRAM read address channel
	output logic                 o_dramra_rdy,
	input  logic                 i_dramra_ack,
	output rdp_data_pkg::gaddr_t o_dramra
);
	import rdp_ctrl_pkg::*;
	import rdp_data_pkg::*;

	loop_state_e state;
	loop_state_e state_nxt;
	len_t        remain;
	gaddr_t      addr;
	logic        addr_xfer;
	logic        last_addr;

	// ================================================================
	// handshakes
	// ================================================================

	// one command at a time, and only with a free slot
	assign o_cmd_ack = i_cmd_rdy && (state == LOOP_IDLE) && !i_buf_full;

	// slot is claimed in the same cycle as the command transfer
	assign o_alloc     = o_cmd_ack;
	assign o_alloc_len = i_cmd_len;

	assign o_dramra_rdy = (state == LOOP_ISSUE);
	assign o_dramra     = addr;

	assign addr_xfer = o_dramra_rdy && i_dramra_ack;
	assign last_addr = (remain == len_t'(1));

	// ================================================================
	// FSM
	// ================================================================

	always_comb begin
		state_nxt = state;
		case (state)
			LOOP_IDLE: begin
				if (o_cmd_ack) begin
					state_nxt = LOOP_ISSUE;
				end
			end
			LOOP_ISSUE: begin
				if (addr_xfer && last_addr) begin
					state_nxt = LOOP_IDLE;
				end
			end
			default: begin
				state_nxt = LOOP_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state  <= LOOP_IDLE;
			remain <= '0;
		end else begin
			state <= state_nxt;
			if (o_cmd_ack) begin
				remain <= i_cmd_len;
			end else if (addr_xfer) begin
				remain <= remain - len_t'(1);
			end
		end
	end

	// address walks up one word per transfer
	always_ff @(posedge i_clk) begin
		if (o_cmd_ack) begin
			addr <= i_cmd_addr;
		end else if (addr_xfer) begin
			addr <= addr + gaddr_t'(1);
		end
	end

endmodule

/* design/rdp_data_pkg.sv */
`include "rdp_consts.svh"

package rdp_data_pkg;

	// ================================================================
	// data path types
	// ================================================================

	// DRAM word address
	typedef logic [`RDP_GADDR_BW - 1:0] gaddr_t;

	typedef logic [`RDP_DATA_BW - 1:0] data_t;

	// one output vector, word 0 in the low bits
	typedef data_t [`RDP_VSIZE - 1:0] vec_t;

	// word address in slot memory, slot index in the upper bits
	typedef logic [$clog2(`RDP_N_SLOTS * `RDP_CHUNK_WORDS) - 1:0] laddr_t;

endpackage

/* design/rdp_ctrl_pkg.sv */
`include "rdp_consts.svh"

package rdp_ctrl_pkg;

	// ================================================================
	// state machines
	// ================================================================

	// address looper
	typedef enum logic {
		LOOP_IDLE,
		LOOP_ISSUE
	} loop_state_e;

	// chunk reader
	typedef enum logic {
		READ_IDLE,
		READ_VEC
	} read_state_e;

	// ================================================================
	// counters and indices
	// ================================================================

	// chunk length, 1 .. RDP_CHUNK_WORDS
	typedef logic [$clog2(`RDP_CHUNK_WORDS + 1) - 1:0] len_t;

	typedef logic [$clog2(`RDP_N_SLOTS) - 1:0] slot_t;

	// vector position inside a chunk
	typedef logic [$clog2(`RDP_CHUNK_WORDS / `RDP_VSIZE) - 1:0] vidx_t;

endpackage

/* design/rdp_consts.svh */
`ifndef RDP_CONSTS_SVH
`define RDP_CONSTS_SVH

// ====================================================================
// sizes shared by the whole read pipeline
// ====================================================================

// global DRAM word address width
`define RDP_GADDR_BW 32

// data word width
`define RDP_DATA_BW 16

// words per output vector
`define RDP_VSIZE 4

// max words per chunk, also words per slot, multiple of vector size
`define RDP_CHUNK_WORDS 8

// buffer slots, also max chunks in flight
`define RDP_N_SLOTS 4

`endif
